//--- rtl/cache_pkg.sv
package cache_pkg;

    localparam int WORD_W      = 16;
    localparam int BLOCK_W     = 64;
    localparam int LINE_COUNT  = 8;
    localparam int LINE_WORDS  = 4;
    localparam int TAG_W       = 11;
    localparam int INDEX_W     = 3;
    localparam int OFFSET_W    = 2;
    localparam int MEM_BLOCKS  = 64;
    localparam int MEM_LATENCY = 4;

    localparam int BLOCK_ADDR_W = TAG_W + INDEX_W;       // tag and index of a line.
    localparam int MEM_ADDR_W   = $clog2(MEM_BLOCKS);    // decoded block bits.
    localparam int LAT_CNT_W    = $clog2(MEM_LATENCY);
    localparam logic [7:0] MEM_PATTERN_HI = 8'hC3;       // high byte after reset.

    // word 0 sits in the top 16 bits of a line
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    typedef enum logic {
        MEM_FILL,
        MEM_WRITEBACK
    } mem_op_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL,
        REFILL_WAIT
    } dcache_state_e;

endpackage

//--- rtl/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if
    import cache_pkg::*;
();

    logic                    req;           // level, held until done.
    mem_op_e                 op;
    logic [BLOCK_ADDR_W-1:0] block_addr;
    logic [BLOCK_W-1:0]      wdata;
    logic [BLOCK_W-1:0]      rdata;         // valid with done on a fill.
    logic                    done;          // one cycle pulse.

    modport cache (
        output req, op, block_addr, wdata,
        input  rdata, done
    );

    modport memory (
        input  req, op, block_addr, wdata,
        output rdata, done
    );

endinterface

//--- rtl/icache.sv
`timescale 1ns/10ps

module icache
    import cache_pkg::*;
(
    input  logic              Clk,
    input  logic              i_arst_n,
    input  logic              i_req,
    input  logic [WORD_W-1:0] i_addr,
    output logic [WORD_W-1:0] o_data,
    output logic              o_busy,
    mem_bus_if.cache          mem
);

    logic [TAG_W-1:0]    tag_q [LINE_COUNT];
    line_t               data_q [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;

    logic [TAG_W-1:0]    addr_tag;
    logic [INDEX_W-1:0]  addr_idx;
    logic [OFFSET_W-1:0] addr_off;
    logic [OFFSET_W-1:0] word_sel;
    logic                hit;

    assign addr_tag = i_addr[WORD_W-1 -: TAG_W];
    assign addr_idx = i_addr[OFFSET_W +: INDEX_W];
    assign addr_off = i_addr[OFFSET_W-1:0];
    assign word_sel = OFFSET_W'(LINE_WORDS - 1) - addr_off;  // word 0 is the top slice.

    assign hit = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);

    assign o_data = data_q[addr_idx][word_sel];
    assign o_busy = i_req && !hit;

    // a fill is asked for as long as the held request misses.
    assign mem.req        = i_req && !hit;
    assign mem.op         = MEM_FILL;
    assign mem.block_addr = {addr_tag, addr_idx};
    assign mem.wdata      = '0;                          // read only cache.

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
        end else if (mem.done) begin
            valid_q[addr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (mem.done) begin
            tag_q[addr_idx]  <= addr_tag;
            data_q[addr_idx] <= mem.rdata;                   // whole line at once.
        end
    end

endmodule

//--- rtl/dcache.sv
`timescale 1ns/10ps

module dcache
    import cache_pkg::*;
(
    input  logic              Clk,
    input  logic              i_arst_n,
    input  logic              i_req,
    input  logic              i_we,
    input  logic [WORD_W-1:0] i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    output logic [WORD_W-1:0] o_rdata,
    output logic              o_busy,
    mem_bus_if.cache          mem
);

    logic [TAG_W-1:0]      tag_q [LINE_COUNT];
    line_t                 data_q [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;

    dcache_state_e state_q;
    dcache_state_e state_d;

    logic [TAG_W-1:0]    addr_tag;
    logic [INDEX_W-1:0]  addr_idx;
    logic [OFFSET_W-1:0] addr_off;
    logic [OFFSET_W-1:0] word_sel;
    logic                hit;
    logic                victim_dirty;
    logic                wr_hit;
    logic                fill_done;

    assign addr_tag = i_addr[WORD_W-1 -: TAG_W];
    assign addr_idx = i_addr[OFFSET_W +: INDEX_W];
    assign addr_off = i_addr[OFFSET_W-1:0];
    assign word_sel = OFFSET_W'(LINE_WORDS - 1) - addr_off;

    assign hit          = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);
    assign victim_dirty = valid_q[addr_idx] && dirty_q[addr_idx];
    assign wr_hit       = (state_q == IDLE) && i_req && i_we && hit;
    assign fill_done    = (state_q == FILL) && mem.done;

    assign o_rdata = data_q[addr_idx][word_sel];
    assign o_busy  = i_req && ((state_q != IDLE) || !hit);

    assign mem.req = (state_q == WRITEBACK) || (state_q == FILL);
    assign mem.op  = (state_q == WRITEBACK) ? MEM_WRITEBACK : MEM_FILL;
    // the victim goes back under its stored tag.
    assign mem.block_addr = (state_q == WRITEBACK) ? {tag_q[addr_idx], addr_idx}
                                                   : {addr_tag, addr_idx};
    assign mem.wdata = data_q[addr_idx];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_req && !hit) begin
                    state_d = victim_dirty ? WRITEBACK : FILL;
                end
            end
            WRITEBACK: begin
                if (mem.done) begin
                    state_d = FILL;                          // op changes next cycle.
                end
            end
            FILL: begin
                if (mem.done) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                state_d = IDLE;                              // access retries as a hit.
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_done) begin
            valid_q[addr_idx] <= 1'b1;
            dirty_q[addr_idx] <= 1'b0;                       // fresh copy of memory.
        end else if (wr_hit) begin
            dirty_q[addr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_done) begin
            tag_q[addr_idx]  <= addr_tag;
            data_q[addr_idx] <= mem.rdata;
        end else if (wr_hit) begin
            data_q[addr_idx][word_sel] <= i_wdata;
        end
    end

endmodule

//--- rtl/block_memory.sv
`timescale 1ns/10ps

module block_memory
    import cache_pkg::*;
(
    input  logic       Clk,
    input  logic       i_arst_n,
    input  logic       i_hold,
    mem_bus_if.memory  ibus,
    mem_bus_if.memory  dbus
);

    line_t mem_q [MEM_BLOCKS];

    logic                 busy_q;
    logic                 gnt_d_q;          // 1 when the data bus owns the memory.
    logic [LAT_CNT_W-1:0] cnt_q;

    logic                 start;
    logic                 last;
    mem_op_e              sel_op;
    logic [MEM_ADDR_W-1:0] sel_blk;
    logic [BLOCK_W-1:0]   sel_wdata;
    logic [BLOCK_W-1:0]   rd_block;

    // pattern word is 0xC3 over the low byte of its own word address
    function automatic line_t init_block(input logic [MEM_ADDR_W-1:0] blk);
        line_t words;
        for (int k = 0; k < LINE_WORDS; k++) begin
            words[LINE_WORDS-1-k] = {MEM_PATTERN_HI, blk, OFFSET_W'(k)};
        end
        return words;
    endfunction

    assign start = !busy_q && !i_hold && (dbus.req || ibus.req);
    assign last  = busy_q && (cnt_q == '0);

    // only the low block bits are decoded, so higher addresses alias.
    assign sel_op    = gnt_d_q ? dbus.op : ibus.op;
    assign sel_blk   = gnt_d_q ? dbus.block_addr[MEM_ADDR_W-1:0]
                               : ibus.block_addr[MEM_ADDR_W-1:0];
    assign sel_wdata = gnt_d_q ? dbus.wdata : ibus.wdata;
    assign rd_block  = mem_q[sel_blk];

    assign ibus.rdata = rd_block;
    assign dbus.rdata = rd_block;
    assign ibus.done  = last && !gnt_d_q;
    assign dbus.done  = last && gnt_d_q;

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q  <= 1'b0;
            gnt_d_q <= 1'b0;
            cnt_q   <= '0;
        end else if (start) begin
            busy_q  <= 1'b1;
            gnt_d_q <= dbus.req;                             // data side wins a tie.
            cnt_q   <= LAT_CNT_W'(MEM_LATENCY - 1);
        end else if (last) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int b = 0; b < MEM_BLOCKS; b++) begin
                mem_q[b] <= init_block(MEM_ADDR_W'(b));
            end
        end else if (last && (sel_op == MEM_WRITEBACK)) begin
            mem_q[sel_blk] <= sel_wdata;
        end
    end

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/10ps

module cache_top
    import cache_pkg::*;
(
    input  logic              Clk,
    input  logic              i_arst_n,
    input  logic              i_hold,
    input  logic              i_ireq,
    input  logic [WORD_W-1:0] i_iaddr,
    output logic [WORD_W-1:0] o_idata,
    output logic              o_ibusy,
    input  logic              i_dreq,
    input  logic              i_dwe,
    input  logic [WORD_W-1:0] i_daddr,
    input  logic [WORD_W-1:0] i_dwdata,
    output logic [WORD_W-1:0] o_drdata,
    output logic              o_dbusy
);

    mem_bus_if ibus_if ();
    mem_bus_if dbus_if ();

    icache u_icache (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_req    (i_ireq),
        .i_addr   (i_iaddr),
        .o_data   (o_idata),
        .o_busy   (o_ibusy),
        .mem      (ibus_if.cache)
    );

    dcache u_dcache (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_req    (i_dreq),
        .i_we     (i_dwe),
        .i_addr   (i_daddr),
        .i_wdata  (i_dwdata),
        .o_rdata  (o_drdata),
        .o_busy   (o_dbusy),
        .mem      (dbus_if.cache)
    );

    // one backing store, hold lets another master own it.
    block_memory u_mem (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_hold   (i_hold),
        .ibus     (ibus_if.memory),
        .dbus     (dbus_if.memory)
    );

endmodule

//--- sim/cache_assertions.sv
`timescale 1ns/10ps

module cache_assertions (
    input logic Clk,
    input logic i_arst_n,
    input logic i_ireq,
    input logic i_idone,
    input logic i_dreq,
    input logic i_ddone
);

    int fail_count = 0;                                  // assertion failures so far.

    a_idone_has_req: assert property (@(posedge Clk) disable iff (!i_arst_n)
        i_idone |-> i_ireq)
        else begin
            fail_count++;
            $error("done on the instruction bus without a request");
        end

    a_ddone_has_req: assert property (@(posedge Clk) disable iff (!i_arst_n)
        i_ddone |-> i_dreq)
        else begin
            fail_count++;
            $error("done on the data bus without a request");
        end

    // only one operation is ever in flight
    a_single_done: assert property (@(posedge Clk) disable iff (!i_arst_n)
        !(i_idone && i_ddone))
        else begin
            fail_count++;
            $error("done on both buses in the same cycle");
        end

    a_ireq_held: assert property (@(posedge Clk) disable iff (!i_arst_n)
        (i_ireq && !i_idone) |=> i_ireq)
        else begin
            fail_count++;
            $error("instruction request dropped before done");
        end

    a_dreq_held: assert property (@(posedge Clk) disable iff (!i_arst_n)
        (i_dreq && !i_ddone) |=> i_dreq)
        else begin
            fail_count++;
            $error("data request dropped before done");
        end

endmodule

//--- sim/cache_tb.sv
`timescale 1ns/10ps

module cache_tb
    import cache_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_GAP      = 3;
    localparam int MAX_LINES    = 64;

    logic              Clk;
    logic              i_arst_n;
    logic              i_hold;
    logic              i_ireq;
    logic [WORD_W-1:0] i_iaddr;
    logic [WORD_W-1:0] o_idata;
    logic              o_ibusy;
    logic              i_dreq;
    logic              i_dwe;
    logic [WORD_W-1:0] i_daddr;
    logic [WORD_W-1:0] i_dwdata;
    logic [WORD_W-1:0] o_drdata;
    logic              o_dbusy;

    string             names [MAX_LINES];
    string             ops [MAX_LINES];
    logic [WORD_W-1:0] addrs [MAX_LINES];
    logic [WORD_W-1:0] wdatas [MAX_LINES];
    logic [WORD_W-1:0] exp_data [MAX_LINES];
    int                holds [MAX_LINES];
    int                line_count;
    int                max_hold;
    int                errors;
    int                tests_failed;
    int unsigned       watchdog_cycles;

    cache_top u_dut (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_hold   (i_hold),
        .i_ireq   (i_ireq),
        .i_iaddr  (i_iaddr),
        .o_idata  (o_idata),
        .o_ibusy  (o_ibusy),
        .i_dreq   (i_dreq),
        .i_dwe    (i_dwe),
        .i_daddr  (i_daddr),
        .i_dwdata (i_dwdata),
        .o_drdata (o_drdata),
        .o_dbusy  (o_dbusy)
    );

    bind block_memory cache_assertions u_bus_checks (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_ireq   (ibus.req),
        .i_idone  (ibus.done),
        .i_dreq   (dbus.req),
        .i_ddone  (dbus.done)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic load_trace(output bit ok);
        int                fd;
        int                fields;
        int                hold;
        string             text;
        string             name;
        string             op;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic [WORD_W-1:0] expd;
        ok = 1'b0;
        line_count = 0;
        max_hold = 0;
        fd = $fopen("sim/cache_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && (line_count < MAX_LINES)) begin
                text = "";
                fields = 0;
                void'($fgets(text, fd));
                if ((text.len() > 0) && (text.getc(0) != "#")) begin
                    fields = $sscanf(text, "%s %s %h %h %h %d",
                                     name, op, addr, wdata, expd, hold);
                end
                if (fields == 6) begin
                    names[line_count]    = name;
                    ops[line_count]      = op;
                    addrs[line_count]    = addr;
                    wdatas[line_count]   = wdata;
                    exp_data[line_count] = expd;
                    holds[line_count]    = hold;
                    max_hold = (hold > max_hold) ? hold : max_hold;
                    line_count++;
                end
            end
            $fclose(fd);
            ok = (line_count > 0);
        end
    endtask

    task automatic check_value(input string test_name, input logic [WORD_W-1:0] expected,
                               input logic [WORD_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h actual %h", test_name, expected, actual);
        end
    endtask

    // samples a quarter cycle before each rising edge until the wanted ports are free
    task automatic wait_ready(input bit want_i, input bit want_d);
        bit ready;
        ready = 1'b0;
        while (!ready) begin
            #(CLK_PERIOD / 4);
            ready = !(want_i && o_ibusy) && !(want_d && o_dbusy);
            if (!ready) begin
                @(negedge Clk);
            end
        end
    endtask

    task automatic run_access(input int k);
        string name;
        bit    use_i;
        bit    use_d;
        int    errs_before;
        int    busy_checks;
        name        = names[k];
        errs_before = errors;
        use_i       = (ops[k] == "I") || (ops[k] == "B");
        use_d       = (ops[k] == "R") || (ops[k] == "W") || (ops[k] == "B");
        i_ireq   = use_i;
        i_iaddr  = addrs[k];
        i_dreq   = use_d;
        i_dwe    = (ops[k] == "W");
        i_daddr  = addrs[k];
        i_dwdata = wdatas[k];
        i_hold   = (holds[k] > 0);
        // a held miss stays busy through the hold and the memory latency after it.
        busy_checks = (holds[k] > 0) ? holds[k] + MEM_LATENCY : 0;
        for (int h = 0; h < busy_checks; h++) begin
            if (h == holds[k]) begin
                i_hold = 1'b0;
            end
            #(CLK_PERIOD / 4);
            if (use_i) begin
                check_value({name, " ibusy"}, WORD_W'(1), WORD_W'(o_ibusy));
            end
            if (use_d) begin
                check_value({name, " dbusy"}, WORD_W'(1), WORD_W'(o_dbusy));
            end
            @(negedge Clk);
        end
        i_hold = 1'b0;
        wait_ready(use_i, use_d);
        if (ops[k] == "W") begin
            @(posedge Clk);
            #(CLK_PERIOD / 4);                         // written word reads back.
            check_value(name, exp_data[k], o_drdata);
        end else begin
            if (use_i) begin
                check_value(name, exp_data[k], o_idata);
            end
            if (use_d) begin
                check_value(name, exp_data[k], o_drdata);
            end
        end
        tests_failed += (errors != errs_before) ? 1 : 0;
        $display("%s: %s", name, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        bit ok;
        int gap;
        void'($urandom(32342));
        errors          = 0;
        tests_failed    = 0;
        watchdog_cycles = 0;
        i_arst_n = 1'b0;
        i_hold   = 1'b0;
        i_ireq   = 1'b0;
        i_iaddr  = '0;
        i_dreq   = 1'b0;
        i_dwe    = 1'b0;
        i_daddr  = '0;
        i_dwdata = '0;
        load_trace(ok);
        if (!ok) begin
            $display("could not read any access from sim/cache_trace.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            watchdog_cycles = RESET_CYCLES
                            + line_count * (2 * (MEM_LATENCY + 3) + max_hold + MAX_GAP);
            repeat (RESET_CYCLES) @(negedge Clk);
            i_arst_n = 1'b1;
            @(negedge Clk);
            for (int k = 0; k < line_count; k++) begin
                run_access(k);
                @(negedge Clk);
                i_ireq = 1'b0;
                i_dreq = 1'b0;
                i_dwe  = 1'b0;
                gap = $urandom_range(MAX_GAP, 0);
                repeat (gap) @(negedge Clk);
            end
            errors += u_dut.u_mem.u_bus_checks.fail_count;
            $display("tests %0d, failed %0d, mismatches and assertion failures %0d",
                     line_count, tests_failed, errors);
            if (errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge Clk);
        $display("timeout: the accesses did not complete within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- sim/cache_trace.txt
# columns: test name, op, address (hex), write data (hex), expected data (hex), hold cycles
# op: I instruction read, R data read, W data write, B instruction and data read together
i_miss       I 0040 0000 C340 0
i_hit        I 0041 0000 C341 0
i_hit_w3     I 0043 0000 C343 0
d_fill       R 0080 0000 C380 0
d_write      W 0081 BEEF BEEF 0
d_readback   R 0081 0000 BEEF 0
d_word2      R 0082 0000 C382 0
d_word0      R 0080 0000 C380 0
wb_write     W 00A4 1234 1234 0
wb_conflict  R 0104 0000 C304 0
wb_reread    R 00A4 0000 1234 0
wb_alias_d   R 01A4 0000 1234 0
wb_alias_w1  R 01A5 0000 C3A5 0
wb_alias_i   I 02A4 0000 1234 0
both_clean   B 0308 0000 C308 2
dirty_set    W 0614 5A5A 5A5A 0
both_dirty   B 0734 0000 C334 0
dirty_back   R 0614 0000 5A5A 0
hold_d       R 0818 0000 C318 3
hold_i       I 091C 0000 C31C 2
hold_wr      W 0A18 7777 7777 4
alias_hold   R 0818 0000 7777 0
alias_wb     R 0180 0000 C380 0
alias_w1     R 0181 0000 BEEF 0
i_after_wb   I 0081 0000 BEEF 0

//--- files.f
rtl/cache_pkg.sv
rtl/mem_bus_if.sv
rtl/icache.sv
rtl/dcache.sv
rtl/block_memory.sv
rtl/cache_top.sv
sim/cache_assertions.sv
sim/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f files.f || exit 1
sim_out="$(./obj_dir/Vcache_tb 2>&1)"
echo "$sim_out"
grep -q "ALL TESTS PASSED" <<< "$sim_out" && exit 0 || exit 1
